// ==== project.f ====
source/counter_lab_pkg.sv
source/strobe_generator.sv
source/counter_bank.sv
source/view_select_fsm.sv
source/counter_view_mux.sv
source/seven_segment_display.sv
source/counter_lab_top.sv
tests/counter_lab_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the counter lab testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -j 0 \
    --top-module counter_lab_tb \
    -f project.f \
    -o counter_lab_sim \
    && ./obj_dir/counter_lab_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"

grep -qx "Result: PASSED" "$LOG" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/counter_lab_tb.sv ====
`timescale 1ns/1ps

module counter_lab_tb
    import counter_lab_pkg::*;
();

    localparam int unsigned CLK_PERIOD   = 8;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned MARGIN       = 50;
    localparam int unsigned PRESS_HOLD   = 3;
    localparam logic [31:0] LFSR_SEED    = 32'h59a7;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    // Enable key modes
    localparam logic [1:0] EN_LOW  = 2'd0;
    localparam logic [1:0] EN_HIGH = 2'd1;
    localparam logic [1:0] EN_RAND = 2'd2;

    typedef struct packed {
        logic        press;
        logic [1:0]  en_mode;
        int unsigned cycles;
        view_e       view;
    } row_t;

    //------------------------------------------------------------------------
    // Stimulus table of key press, enable mode, row length and view after press

    localparam int unsigned N_ROWS = 9;
    localparam row_t ROWS [N_ROWS] = '{
        '{1'b0, EN_HIGH, 20, VIEW_FREE_LOW },
        '{1'b1, EN_HIGH, 12, VIEW_FREE_HIGH},
        '{1'b1, EN_HIGH, 30, VIEW_UP       },
        '{1'b1, EN_HIGH, 35, VIEW_DOWN     },
        '{1'b1, EN_RAND, 60, VIEW_ENABLED  },
        '{1'b0, EN_RAND, 40, VIEW_ENABLED  },
        '{1'b1, EN_HIGH, 40, VIEW_STROBES  },
        '{1'b1, EN_LOW,  20, VIEW_FREE_LOW },
        '{1'b0, EN_RAND, 15, VIEW_FREE_LOW }
    };

    logic               clk;
    logic               i_rst;
    logic               i_key_next;
    logic               i_key_enable;
    logic [W_LED - 1:0] o_led;
    logic [7:0]         o_abcdefgh;
    logic [N_DIGIT-1:0] o_digit;

    // Reference model state as seen after the latest edge
    int unsigned m_cyc;
    int unsigned m_up;
    int unsigned m_down;
    int unsigned m_en;
    int unsigned m_strobes;
    int unsigned m_refresh;
    int unsigned m_idx;
    logic        m_key_prev;
    view_e       m_view;
    logic [7:0]  m_seg;

    logic [31:0] lfsr;
    int unsigned errors;
    int unsigned checks;

    counter_lab_top counter_lab_top_inst
    (
        .clk          ( clk          ),
        .i_rst        ( i_rst        ),
        .i_key_next   ( i_key_next   ),
        .i_key_enable ( i_key_enable ),
        .o_led        ( o_led        ),
        .o_abcdefgh   ( o_abcdefgh   ),
        .o_digit      ( o_digit      )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //------------------------------------------------------------------------
    // Helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            lfsr_step = (state >> 1) ^ LFSR_TAPS;
        else
            lfsr_step = state >> 1;
    endfunction

    // Segments a to g from the top bit down and the dot last
    function automatic logic [7:0] hex_segments(input logic [3:0] value);
        case (value)
            4'h0    : hex_segments = 8'b1111_1100;
            4'h1    : hex_segments = 8'b0110_0000;
            4'h2    : hex_segments = 8'b1101_1010;
            4'h3    : hex_segments = 8'b1111_0010;
            4'h4    : hex_segments = 8'b0110_0110;
            4'h5    : hex_segments = 8'b1011_0110;
            4'h6    : hex_segments = 8'b1011_1110;
            4'h7    : hex_segments = 8'b1110_0000;
            4'h8    : hex_segments = 8'b1111_1110;
            4'h9    : hex_segments = 8'b1111_0110;
            4'ha    : hex_segments = 8'b1110_1110;
            4'hb    : hex_segments = 8'b0011_1110;
            4'hc    : hex_segments = 8'b1001_1100;
            4'hd    : hex_segments = 8'b0111_1010;
            4'he    : hex_segments = 8'b1001_1110;
            default : hex_segments = 8'b1000_1110;
        endcase
    endfunction

    // Number that the display shows for a view
    function automatic logic [31:0] selected_value(input view_e view);
        case (view)
            VIEW_FREE_LOW  : selected_value = m_cyc;
            VIEW_FREE_HIGH : selected_value = (m_cyc >> 24) & 32'hFF;
            VIEW_UP        : selected_value = m_up;
            VIEW_DOWN      : selected_value = m_down;
            VIEW_ENABLED   : selected_value = m_en;
            default        : selected_value = m_strobes & 32'hFFFF;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAIL t=%0t signal %s expected 0x%0h actual 0x%0h",
                 $time, name, expected, actual);
    endtask

    task automatic model_reset();
        m_cyc      = 0;
        m_up       = 0;
        m_down     = MAX_DOWN;
        m_en       = 0;
        m_strobes  = 0;
        m_refresh  = 0;
        m_idx      = 0;
        m_key_prev = 1'b0;
        m_view     = VIEW_FREE_LOW;
        m_seg      = hex_segments(4'h0);
    endtask

    // Advance the model across one rising edge
    task automatic model_step(input logic key, input logic en);
        logic [31:0] number;
        logic        strobe;

        number = selected_value(m_view);
        strobe = (m_cyc != 0) && (m_cyc % STROBE_PERIOD == 0);

        if (strobe)
        begin
            m_up      = (m_up == MAX_UP) ? 0 : m_up + 1;
            m_down    = (m_down == 0) ? MAX_DOWN : m_down - 1;
            m_strobes = m_strobes + 1;
            if (en)
                m_en = (m_en == MAX_EN) ? 0 : m_en + 1;
        end

        if (key && !m_key_prev)
        begin
            if (m_view == VIEW_STROBES)
                m_view = VIEW_FREE_LOW;
            else
                m_view = view_e'(m_view + 3'd1);
        end
        m_key_prev = key;
        m_cyc      = m_cyc + 1;

        m_refresh = m_refresh + 1;
        if (m_refresh == REFRESH_DIV)
        begin
            m_refresh = 0;
            m_idx     = (m_idx + 1) % N_DIGIT;
        end
        m_seg = hex_segments(4'((number >> (4 * m_idx)) & 32'hF));
    endtask

    task automatic check_outputs();
        logic [31:0] exp_led;
        logic [31:0] exp_digit;

        exp_led   = selected_value(m_view) & 32'hFF;
        exp_digit = 32'h1 << m_idx;
        checks    = checks + 3;

        if (32'(o_led) !== exp_led)
            report_mismatch("o_led", exp_led, 32'(o_led));
        if (32'(o_digit) !== exp_digit)
            report_mismatch("o_digit", exp_digit, 32'(o_digit));
        if (o_abcdefgh !== m_seg)
            report_mismatch("o_abcdefgh", 32'(m_seg), 32'(o_abcdefgh));
    endtask

    // Drive just after the edge and check just before the next one
    task automatic run_cycle(input logic key, input logic en);
        i_key_next   = key;
        i_key_enable = en;
        #(CLK_PERIOD - 2);
        check_outputs();
        model_step(key, en);
        @(posedge clk);
        #1;
    endtask

    //------------------------------------------------------------------------
    // Main sequence

    initial
    begin
        logic        key;
        logic        en;
        logic [31:0] exp_led;

        i_rst        = 1'b1;
        i_key_next   = 1'b0;
        i_key_enable = 1'b0;
        errors       = 0;
        checks       = 0;
        lfsr         = LFSR_SEED;
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        i_rst = 1'b0;

        for (int unsigned r = 0; r < N_ROWS; r++)
        begin
            for (int unsigned c = 0; c < ROWS[r].cycles; c++)
            begin
                key = ROWS[r].press && (c < PRESS_HOLD);
                case (ROWS[r].en_mode)
                    EN_LOW  : en = 1'b0;
                    EN_HIGH : en = 1'b1;
                    default :
                    begin
                        lfsr = lfsr_step(lfsr);
                        en   = lfsr[0];
                    end
                endcase
                run_cycle(key, en);
            end

            // LEDs must show the view that the table expects
            exp_led = selected_value(ROWS[r].view) & 32'hFF;
            checks  = checks + 1;
            if (32'(o_led) !== exp_led)
                report_mismatch("o_led at row end", exp_led, 32'(o_led));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    //------------------------------------------------------------------------
    // Timeout

    initial
    begin
        int unsigned limit;
        int unsigned cycle_cnt;

        limit = RESET_CYCLES + MARGIN;
        for (int unsigned r = 0; r < N_ROWS; r++)
            limit = limit + ROWS[r].cycles;

        cycle_cnt = 0;
        while (cycle_cnt < limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end

        $display("ERROR: the run did not finish within %0d clock cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== source/counter_lab_top.sv ====
`timescale 1ns/1ps

module counter_lab_top
    import counter_lab_pkg::*;
(
    input                        clk,
    input                        i_rst,
    input                        i_key_next,
    input                        i_key_enable,

    output logic [W_LED   - 1:0] o_led,
    output logic [          7:0] o_abcdefgh,
    output logic [N_DIGIT - 1:0] o_digit
);

    //------------------------------------------------------------------------
    // Slow strobe in place of a second clock

    logic strobe;

    strobe_generator strobe_generator_inst
    (
        .clk      ( clk    ),
        .i_rst    ( i_rst  ),
        .o_strobe ( strobe )
    );

    //------------------------------------------------------------------------

    logic [W_FREE       - 1:0] free_cnt;
    logic [W_SMALL      - 1:0] up_cnt;
    logic [W_SMALL      - 1:0] down_cnt;
    logic [W_SMALL      - 1:0] en_cnt;
    logic [W_STROBE_CNT - 1:0] strobe_cnt;

    counter_bank counter_bank_inst
    (
        .clk          ( clk          ),
        .i_rst        ( i_rst        ),
        .i_strobe     ( strobe       ),
        .i_enable     ( i_key_enable ),
        .o_free_cnt   ( free_cnt     ),
        .o_up_cnt     ( up_cnt       ),
        .o_down_cnt   ( down_cnt     ),
        .o_en_cnt     ( en_cnt       ),
        .o_strobe_cnt ( strobe_cnt   )
    );

    //------------------------------------------------------------------------
    // Key steps through the views

    view_e view;

    view_select_fsm view_select_fsm_inst
    (
        .clk    ( clk        ),
        .i_rst  ( i_rst      ),
        .i_next ( i_key_next ),
        .o_view ( view       )
    );

    //------------------------------------------------------------------------

    logic [W_NUMBER - 1:0] number;

    counter_view_mux counter_view_mux_inst
    (
        .i_view       ( view       ),
        .i_free_cnt   ( free_cnt   ),
        .i_up_cnt     ( up_cnt     ),
        .i_down_cnt   ( down_cnt   ),
        .i_en_cnt     ( en_cnt     ),
        .i_strobe_cnt ( strobe_cnt ),
        .o_led        ( o_led      ),
        .o_number     ( number     )
    );

    //------------------------------------------------------------------------

    seven_segment_display seven_segment_display_inst
    (
        .clk        ( clk        ),
        .i_rst      ( i_rst      ),
        .i_number   ( number     ),
        .o_abcdefgh ( o_abcdefgh ),
        .o_digit    ( o_digit    )
    );

endmodule

// ==== source/seven_segment_display.sv ====
`timescale 1ns/1ps

module seven_segment_display
    import counter_lab_pkg::*;
(
    input                         clk,
    input                         i_rst,
    input        [W_NUMBER - 1:0] i_number,

    output logic [           7:0] o_abcdefgh,
    output logic [N_DIGIT  - 1:0] o_digit
);

    logic [W_REFRESH_CNT - 1:0] refresh_cnt;
    logic                       refresh_last;
    logic [W_DIGIT_IDX   - 1:0] digit_idx;
    logic [W_DIGIT_IDX   - 1:0] digit_idx_next;
    logic [3:0]                 nibble;
    logic [7:0]                 segments;

    //------------------------------------------------------------------------
    // Refresh divider and digit index

    assign refresh_last = (refresh_cnt == W_REFRESH_CNT'(REFRESH_DIV - 1));

    always_comb
    begin
        digit_idx_next = digit_idx;

        if (refresh_last)
        begin
            if (digit_idx == W_DIGIT_IDX'(N_DIGIT - 1))
                digit_idx_next = '0;
            else
                digit_idx_next = digit_idx + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            refresh_cnt <= '0;
            digit_idx   <= '0;
            o_digit     <= N_DIGIT'(1);
        end
        else
        begin
            if (refresh_last)
                refresh_cnt <= '0;
            else
                refresh_cnt <= refresh_cnt + 1'b1;

            digit_idx <= digit_idx_next;
            o_digit   <= N_DIGIT'(1) << digit_idx_next;
        end
    end

    //------------------------------------------------------------------------
    // Hex to segments with a in the top bit and the dot dark

    assign nibble = i_number[digit_idx_next * 4 +: 4];

    always_comb
    begin
        case (nibble)
            4'h0    : segments = 8'b1111_1100;
            4'h1    : segments = 8'b0110_0000;
            4'h2    : segments = 8'b1101_1010;
            4'h3    : segments = 8'b1111_0010;
            4'h4    : segments = 8'b0110_0110;
            4'h5    : segments = 8'b1011_0110;
            4'h6    : segments = 8'b1011_1110;
            4'h7    : segments = 8'b1110_0000;
            4'h8    : segments = 8'b1111_1110;
            4'h9    : segments = 8'b1111_0110;
            4'ha    : segments = 8'b1110_1110;
            4'hb    : segments = 8'b0011_1110;
            4'hc    : segments = 8'b1001_1100;
            4'hd    : segments = 8'b0111_1010;
            4'he    : segments = 8'b1001_1110;
            default : segments = 8'b1000_1110;
        endcase
    end

    // Pattern lines up with the digit select loaded on the same edge
    always_ff @(posedge clk)
        o_abcdefgh <= segments;

endmodule

// ==== source/counter_view_mux.sv ====
`timescale 1ns/1ps

module counter_view_mux
    import counter_lab_pkg::*;
(
    input  view_e                     i_view,
    input        [W_FREE       - 1:0] i_free_cnt,
    input        [W_SMALL      - 1:0] i_up_cnt,
    input        [W_SMALL      - 1:0] i_down_cnt,
    input        [W_SMALL      - 1:0] i_en_cnt,
    input        [W_STROBE_CNT - 1:0] i_strobe_cnt,

    output logic [W_LED        - 1:0] o_led,
    output logic [W_NUMBER     - 1:0] o_number
);

    always_comb
    begin
        case (i_view)
            VIEW_FREE_LOW  : o_led = W_LED'(i_free_cnt);
            VIEW_FREE_HIGH : o_led = i_free_cnt[W_FREE - 1 -: W_LED];
            VIEW_UP        : o_led = W_LED'(i_up_cnt);
            VIEW_DOWN      : o_led = W_LED'(i_down_cnt);
            VIEW_ENABLED   : o_led = W_LED'(i_en_cnt);
            VIEW_STROBES   : o_led = W_LED'(i_strobe_cnt);
            default        : o_led = '0;
        endcase
    end

    // The low view puts the whole free counter on the display
    always_comb
    begin
        case (i_view)
            VIEW_FREE_LOW  : o_number = W_NUMBER'(i_free_cnt);
            VIEW_FREE_HIGH : o_number = W_NUMBER'(i_free_cnt[W_FREE - 1 -: W_LED]);
            VIEW_UP        : o_number = W_NUMBER'(i_up_cnt);
            VIEW_DOWN      : o_number = W_NUMBER'(i_down_cnt);
            VIEW_ENABLED   : o_number = W_NUMBER'(i_en_cnt);
            VIEW_STROBES   : o_number = W_NUMBER'(i_strobe_cnt);
            default        : o_number = '0;
        endcase
    end

endmodule

// ==== source/view_select_fsm.sv ====
`timescale 1ns/1ps

module view_select_fsm
    import counter_lab_pkg::*;
(
    input         clk,
    input         i_rst,
    input         i_next,
    output view_e o_view
);

    view_e view_next;
    logic  next_prev;
    logic  next_rise;

    // Press seen only on the edge where the key first goes high
    assign next_rise = i_next && !next_prev;

    always_comb
    begin
        case (o_view)
            VIEW_FREE_LOW  : view_next = VIEW_FREE_HIGH;
            VIEW_FREE_HIGH : view_next = VIEW_UP;
            VIEW_UP        : view_next = VIEW_DOWN;
            VIEW_DOWN      : view_next = VIEW_ENABLED;
            VIEW_ENABLED   : view_next = VIEW_STROBES;
            VIEW_STROBES   : view_next = VIEW_FREE_LOW;
            default        : view_next = VIEW_FREE_LOW;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            next_prev <= 1'b0;
            o_view    <= VIEW_FREE_LOW;
        end
        else
        begin
            next_prev <= i_next;

            if (next_rise)
                o_view <= view_next;
        end
    end

endmodule

// ==== source/counter_bank.sv ====
`timescale 1ns/1ps

module counter_bank
    import counter_lab_pkg::*;
(
    input                             clk,
    input                             i_rst,
    input                             i_strobe,
    input                             i_enable,

    output logic [W_FREE       - 1:0] o_free_cnt,
    output logic [W_SMALL      - 1:0] o_up_cnt,
    output logic [W_SMALL      - 1:0] o_down_cnt,
    output logic [W_SMALL      - 1:0] o_en_cnt,
    output logic [W_STROBE_CNT - 1:0] o_strobe_cnt
);

    //------------------------------------------------------------------------
    // Free-running counter that steps on every clock

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_free_cnt <= '0;
        else
            o_free_cnt <= o_free_cnt + 1'b1;
    end

    //------------------------------------------------------------------------
    // Up counter that wraps to zero after MAX_UP

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_up_cnt <= '0;
        else if (i_strobe)
        begin
            if (o_up_cnt == W_SMALL'(MAX_UP))
                o_up_cnt <= '0;
            else
                o_up_cnt <= o_up_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Down counter that reloads MAX_DOWN once it has reached zero

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_down_cnt <= W_SMALL'(MAX_DOWN);
        else if (i_strobe)
        begin
            if (o_down_cnt == '0)
                o_down_cnt <= W_SMALL'(MAX_DOWN);
            else
                o_down_cnt <= o_down_cnt - 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Counter held by the enable key

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_en_cnt <= '0;
        else if (i_strobe && i_enable)
        begin
            if (o_en_cnt == W_SMALL'(MAX_EN))
                o_en_cnt <= '0;
            else
                o_en_cnt <= o_en_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Number of strobes seen since reset

    always_ff @(posedge clk)
    begin
        if (i_rst)
            o_strobe_cnt <= '0;
        else if (i_strobe)
            o_strobe_cnt <= o_strobe_cnt + 1'b1;
    end

endmodule

// ==== source/strobe_generator.sv ====
`timescale 1ns/1ps

module strobe_generator
    import counter_lab_pkg::*;
(
    input        clk,
    input        i_rst,
    output logic o_strobe
);

    // Phase within one strobe period
    logic [W_STROBE_PHASE - 1:0] phase;
    logic                        phase_last;

    assign phase_last = (phase == W_STROBE_PHASE'(STROBE_PERIOD - 1));

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            phase    <= '0;
            o_strobe <= 1'b0;
        end
        else
        begin
            if (phase_last)
                phase <= '0;
            else
                phase <= phase + 1'b1;

            // One cycle high after the last phase
            o_strobe <= phase_last;
        end
    end

endmodule

// ==== source/counter_lab_pkg.sv ====
package counter_lab_pkg;

    //------------------------------------------------------------------------
    // Counter widths

    localparam int unsigned W_FREE       = 32;
    localparam int unsigned W_STROBE_CNT = 16;
    localparam int unsigned W_SMALL      = 4;

    //------------------------------------------------------------------------
    // Slow strobe and counter limits

    // Stands in for the separate slow clock of the board
    localparam int unsigned STROBE_PERIOD  = 5;
    localparam int unsigned W_STROBE_PHASE = $clog2(STROBE_PERIOD);

    localparam int unsigned MAX_UP   = 4;
    localparam int unsigned MAX_DOWN = 5;
    localparam int unsigned MAX_EN   = 8;

    //------------------------------------------------------------------------
    // LEDs and the scanned display

    localparam int unsigned W_LED         = 8;
    localparam int unsigned N_DIGIT       = 8;
    localparam int unsigned W_NUMBER      = N_DIGIT * 4;
    localparam int unsigned W_DIGIT_IDX   = $clog2(N_DIGIT);
    localparam int unsigned REFRESH_DIV   = 4;
    localparam int unsigned W_REFRESH_CNT = $clog2(REFRESH_DIV);

    //------------------------------------------------------------------------
    // Sources that can be shown in key order

    typedef enum logic [2:0] {
        VIEW_FREE_LOW,
        VIEW_FREE_HIGH,
        VIEW_UP,
        VIEW_DOWN,
        VIEW_ENABLED,
        VIEW_STROBES
    } view_e;

endpackage
